//--- common/isa_pkg.sv
package isa_pkg;

    // ======================================================================
    // widths
    // ======================================================================
    localparam int data_w    = 16;
    localparam int addr_w    = 16;  // pc width.
    localparam int gp_n      = 16;
    localparam int sr_n      = 4;
    localparam int gp_addr_w = $clog2(gp_n);
    localparam int sr_addr_w = $clog2(sr_n);
    localparam int imm_w     = 8;
    localparam int opc_w     = 5;
    localparam int shamt_w   = 4;   // low bits of operand b.

    typedef logic [data_w-1:0]    data_t;
    typedef logic [addr_w-1:0]    pc_t;
    typedef logic [data_w-1:0]    instr_t;  // trace only.
    typedef logic [gp_addr_w-1:0] gp_addr_t;
    typedef logic [sr_addr_w-1:0] sr_addr_t;
    typedef logic [imm_w-1:0]     imm_t;
    typedef logic [shamt_w-1:0]   shamt_t;

    // signed clamp limits for the saturating ops.
    localparam data_t sat_max = {1'b0, {(data_w-1){1'b1}}};
    localparam data_t sat_min = {1'b1, {(data_w-1){1'b0}}};

    // ======================================================================
    // opcodes
    // ======================================================================
    typedef enum logic [opc_w-1:0] {
        opc_nop   = 5'd0,   // no instruction.
        // R group
        opc_mov   = 5'd1,
        opc_add   = 5'd2,
        opc_sub   = 5'd3,
        opc_not   = 5'd4,
        opc_and   = 5'd5,
        opc_or    = 5'd6,
        opc_xor   = 5'd7,
        opc_shl   = 5'd8,
        opc_shr   = 5'd9,
        // RS group, signed
        opc_adds  = 5'd10,
        opc_subs  = 5'd11,
        opc_shrs  = 5'd12,
        // I group, zero-extended immediate
        opc_movi  = 5'd13,
        opc_addi  = 5'd14,
        opc_subi  = 5'd15,
        opc_andi  = 5'd16,
        opc_ori   = 5'd17,
        opc_xori  = 5'd18,
        opc_shli  = 5'd19,
        opc_shri  = 5'd20,
        // IS group, sign-extended immediate
        opc_movis = 5'd21,
        opc_addis = 5'd22,
        opc_subis = 5'd23,
        opc_shris = 5'd24,
        opc_srmov = 5'd25   // gp to sr move.
    } opc_t;

endpackage

//--- common/pipe_pkg.sv
package pipe_pkg;
    import isa_pkg::*;

    typedef struct packed {
        pc_t      pc;
        instr_t   instr;
        opc_t     opc;
        gp_addr_t tgt_gp;
        sr_addr_t tgt_sr;
        gp_addr_t src_a;
        gp_addr_t src_b;
        imm_t     imm;
    } issue_t;

    typedef struct packed {
        pc_t      pc;
        instr_t   instr;
        opc_t     opc;
        gp_addr_t tgt_gp;
        sr_addr_t tgt_sr;
        data_t    result;
    } ex_wb_t;

    typedef struct packed {
        logic     en;
        gp_addr_t addr;
        data_t    data;
    } gp_wr_t;

    typedef struct packed {
        logic     en;
        sr_addr_t addr;
        data_t    data;
    } sr_wr_t;

    // same layout as ex_wb_t, one stage later.
    typedef struct packed {
        pc_t      pc;
        instr_t   instr;
        opc_t     opc;
        gp_addr_t tgt_gp;
        sr_addr_t tgt_sr;
        data_t    result;
    } retire_t;

endpackage

//--- verilog/register_file.sv
`timescale 1ns/1ns

module register_file
    import isa_pkg::*;
#(
    parameter int n_regs = gp_n,
    parameter int addr_w = gp_addr_w
) (
    input  logic              iw_clk,
    input  logic              iw_rst,
    input  logic              wr_en,
    input  logic [addr_w-1:0] wr_addr,
    input  data_t             wr_data,
    input  logic [addr_w-1:0] rd_addr_a,
    input  logic [addr_w-1:0] rd_addr_b,
    output data_t             rd_data_a,
    output data_t             rd_data_b
);

    data_t regs [n_regs];

    // ======================================================================
    // write port
    // ======================================================================
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < n_regs; i++) begin
                regs[i] <= '0;
            end
        end
        else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // ======================================================================
    // read ports
    // ======================================================================
    // no internal bypass, a same-cycle write shows up next cycle.
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

//--- backend/exec_stage.sv
`timescale 1ns/1ns

module exec_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic   iw_clk,
    input  logic   iw_rst,
    input  issue_t issue,
    input  data_t  rd_a,
    input  data_t  rd_b,
    input  gp_wr_t fwd,
    output ex_wb_t ex_wb
);

    logic   fwd_a;
    logic   fwd_b;
    data_t  op_a;
    data_t  gp_b;
    data_t  op_b;
    data_t  imm_zx;
    data_t  imm_sx;
    shamt_t shamt;
    data_t  result;

    // signed add or subtract, clamped on overflow.
    function automatic data_t sat_add(input data_t a, input data_t b, input logic sub);
        logic [data_w:0] sum;
        if (sub) begin
            sum = {a[data_w-1], a} - {b[data_w-1], b};
        end
        else begin
            sum = {a[data_w-1], a} + {b[data_w-1], b};
        end
        if (sum[data_w] != sum[data_w-1]) begin
            return sum[data_w] ? sat_min : sat_max;
        end
        return sum[data_w-1:0];
    endfunction

    // ======================================================================
    // operand select
    // ======================================================================
    // the instruction in write-back is the only one not yet in the file.
    assign fwd_a = fwd.en && (fwd.addr == issue.src_a);
    assign fwd_b = fwd.en && (fwd.addr == issue.src_b);
    assign op_a  = fwd_a ? fwd.data : rd_a;
    assign gp_b  = fwd_b ? fwd.data : rd_b;

    assign imm_zx = {{(data_w-imm_w){1'b0}}, issue.imm};
    assign imm_sx = {{(data_w-imm_w){issue.imm[imm_w-1]}}, issue.imm};

    always_comb begin
        case (issue.opc)
            opc_movi, opc_addi, opc_subi, opc_andi,
            opc_ori, opc_xori, opc_shli, opc_shri: begin
                op_b = imm_zx;
            end
            opc_movis, opc_addis, opc_subis, opc_shris: begin
                op_b = imm_sx;
            end
            default: begin
                op_b = gp_b;
            end
        endcase
    end

    assign shamt = op_b[shamt_w-1:0];

    // ======================================================================
    // alu
    // ======================================================================
    always_comb begin
        case (issue.opc)
            opc_mov, opc_srmov:   result = op_a;
            opc_movi, opc_movis:  result = op_b;  // extended immediate.
            opc_add, opc_addi:    result = op_a + op_b;
            opc_sub, opc_subi:    result = op_a - op_b;
            opc_adds, opc_addis:  result = sat_add(op_a, op_b, 1'b0);
            opc_subs, opc_subis:  result = sat_add(op_a, op_b, 1'b1);
            opc_not:              result = ~op_a;
            opc_and, opc_andi:    result = op_a & op_b;
            opc_or, opc_ori:      result = op_a | op_b;
            opc_xor, opc_xori:    result = op_a ^ op_b;
            opc_shl, opc_shli:    result = op_a << shamt;
            opc_shr, opc_shri:    result = op_a >> shamt;
            opc_shrs, opc_shris:  result = data_t'($signed(op_a) >>> shamt);
            default:              result = '0;  // nop.
        endcase
    end

    // ======================================================================
    // execute to write-back register
    // ======================================================================
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            ex_wb <= '0;
        end
        else begin
            ex_wb.pc     <= issue.pc;
            ex_wb.instr  <= issue.instr;
            ex_wb.opc    <= issue.opc;
            ex_wb.tgt_gp <= issue.tgt_gp;
            ex_wb.tgt_sr <= issue.tgt_sr;
            ex_wb.result <= result;
        end
    end

endmodule

//--- backend/writeback_stage.sv
`timescale 1ns/1ns

module writeback_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic    iw_clk,
    input  logic    iw_rst,
    input  ex_wb_t  ex_wb,
    output gp_wr_t  gp_wr,
    output sr_wr_t  sr_wr,
    output retire_t retire
);

    logic gp_we;

    // every r, rs, i and is opcode writes a gp register.
    always_comb begin
        case (ex_wb.opc)
            opc_mov, opc_add, opc_sub, opc_not, opc_and,
            opc_or, opc_xor, opc_shl, opc_shr,
            opc_adds, opc_subs, opc_shrs,
            opc_movi, opc_addi, opc_subi, opc_andi,
            opc_ori, opc_xori, opc_shli, opc_shri,
            opc_movis, opc_addis, opc_subis, opc_shris: begin
                gp_we = 1'b1;
            end
            default: begin
                gp_we = 1'b0;
            end
        endcase
    end

    assign gp_wr.en   = gp_we;
    assign gp_wr.addr = ex_wb.tgt_gp;
    assign gp_wr.data = ex_wb.result;

    assign sr_wr.en   = (ex_wb.opc == opc_srmov);
    assign sr_wr.addr = ex_wb.tgt_sr;
    assign sr_wr.data = ex_wb.result;

    // ======================================================================
    // retire trace
    // ======================================================================
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            retire <= '0;   // opc reads as nop.
        end
        else begin
            retire.pc     <= ex_wb.pc;
            retire.instr  <= ex_wb.instr;
            retire.opc    <= ex_wb.opc;
            retire.tgt_gp <= ex_wb.tgt_gp;
            retire.tgt_sr <= ex_wb.tgt_sr;
            retire.result <= ex_wb.result;
        end
    end

endmodule

//--- backend/backend_top.sv
`timescale 1ns/1ns

module backend_top
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     iw_clk,
    input  logic     iw_rst,
    input  issue_t   issue,
    input  sr_addr_t sr_rd_addr,
    output data_t    sr_rd_data,
    output gp_wr_t   gp_wr,
    output retire_t  retire
);

    ex_wb_t ex_wb;
    sr_wr_t sr_wr;
    data_t  rd_a;
    data_t  rd_b;

    exec_stage exec_stage_i (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .issue  (issue),
        .rd_a   (rd_a),
        .rd_b   (rd_b),
        .fwd    (gp_wr),    // write-back port doubles as bypass.
        .ex_wb  (ex_wb)
    );

    writeback_stage writeback_stage_i (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .ex_wb  (ex_wb),
        .gp_wr  (gp_wr),
        .sr_wr  (sr_wr),
        .retire (retire)
    );

    register_file #(
        .n_regs (gp_n),
        .addr_w (gp_addr_w)
    ) gp_rf (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .wr_en     (gp_wr.en),
        .wr_addr   (gp_wr.addr),
        .wr_data   (gp_wr.data),
        .rd_addr_a (issue.src_a),
        .rd_addr_b (issue.src_b),
        .rd_data_a (rd_a),
        .rd_data_b (rd_b)
    );

    register_file #(
        .n_regs (sr_n),
        .addr_w (sr_addr_w)
    ) sr_rf (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .wr_en     (sr_wr.en),
        .wr_addr   (sr_wr.addr),
        .wr_data   (sr_wr.data),
        .rd_addr_a (sr_rd_addr),
        .rd_addr_b ('0),        // port b unused.
        .rd_data_a (sr_rd_data),
        .rd_data_b ()
    );

endmodule

//--- testbench/tb_backend.sv
`timescale 1ns/1ns

module tb_backend
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int rst_cycles  = 8;
    localparam int n_rows      = 27;
    localparam int n_rand      = 200;
    localparam int cycle_limit = rst_cycles + n_rows + n_rand + 20;

    logic     iw_clk;
    logic     iw_rst;
    issue_t   issue;
    sr_addr_t sr_rd_addr;
    data_t    sr_rd_data;
    gp_wr_t   gp_wr;
    retire_t  retire;

    issue_t      rows [n_rows];
    data_t       row_exp [n_rows];
    int          row_cnt = 0;
    data_t       gp_model [gp_n];
    data_t       sr_model [sr_n];   // sr contents as of the last retire.
    retire_t     exp_q [$];         // [retire, write-back].
    logic [31:0] lfsr = 32'h96aa_4f4e;
    int          cycle_cnt = 0;
    int          step_cnt = 0;
    pc_t         next_pc = 16'h0100;

    backend_top dut_i (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .issue      (issue),
        .sr_rd_addr (sr_rd_addr),
        .sr_rd_data (sr_rd_data),
        .gp_wr      (gp_wr),
        .retire     (retire)
    );

    initial begin
        iw_clk = 1'b0;
        forever #10 iw_clk = ~iw_clk;
    end

    always @(posedge iw_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("run timed out after %0d cycles without finishing", cycle_cnt);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // ======================================================================
    // random source and reference model
    // ======================================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    task automatic draw(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic writes_gp(input opc_t opc);
        return (opc >= opc_mov) && (opc <= opc_shris);
    endfunction

    function automatic data_t clamp16(input int v);
        if (v > 32767) return 16'h7fff;
        if (v < -32768) return 16'h8000;
        return v[15:0];
    endfunction

    function automatic data_t model_result(input opc_t opc, input data_t a, input data_t b,
                                           input imm_t imm);
        data_t      ob;
        int         sa;
        int         sb;
        logic [3:0] sh;
        ob = b;
        if (opc >= opc_movi && opc <= opc_shri) ob = {8'h00, imm};
        if (opc >= opc_movis && opc <= opc_shris) ob = {{8{imm[7]}}, imm};
        sa = $signed(a);
        sb = $signed(ob);
        sh = ob[3:0];
        case (opc)
            opc_mov, opc_srmov:  return a;
            opc_movi, opc_movis: return ob;
            opc_add, opc_addi:   return a + ob;
            opc_sub, opc_subi:   return a - ob;
            opc_adds, opc_addis: return clamp16(sa + sb);
            opc_subs, opc_subis: return clamp16(sa - sb);
            opc_not:             return ~a;
            opc_and, opc_andi:   return a & ob;
            opc_or, opc_ori:     return a | ob;
            opc_xor, opc_xori:   return a ^ ob;
            opc_shl, opc_shli:   return a << sh;
            opc_shr, opc_shri:   return a >> sh;
            opc_shrs, opc_shris: return (a >> sh) | (a[15] ? ~(16'hffff >> sh) : 16'h0000);
            default:             return 16'h0000;
        endcase
    endfunction

    // ======================================================================
    // compare tasks
    // ======================================================================
    task automatic stop_on_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) stop_on_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_instr(input instr_t got, input instr_t exp, input string what);
        if (got !== exp) stop_on_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_opc(input opc_t got, input opc_t exp, input string what);
        if (got !== exp) stop_on_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_pc(input pc_t got, input pc_t exp, input string what);
        if (got !== exp) stop_on_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_gp_addr(input gp_addr_t got, input gp_addr_t exp, input string what);
        if (got !== exp) stop_on_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_sr_addr(input sr_addr_t got, input sr_addr_t exp, input string what);
        if (got !== exp) stop_on_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) stop_on_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_idle();
        check_opc(retire.opc, opc_nop, "retire.opc in reset");
        check_flag(gp_wr.en, 1'b0, "gp_wr.en in reset");
        check_flag(dut_i.sr_wr.en, 1'b0, "sr_wr.en in reset");
    endtask

    // ======================================================================
    // stimulus
    // ======================================================================
    function automatic issue_t mk_issue(input opc_t opc, input gp_addr_t tgt_gp,
                                        input sr_addr_t tgt_sr, input gp_addr_t a,
                                        input gp_addr_t b, input imm_t imm);
        issue_t iss;
        iss        = '0;
        iss.opc    = opc;
        iss.tgt_gp = tgt_gp;
        iss.tgt_sr = tgt_sr;
        iss.src_a  = a;
        iss.src_b  = b;
        iss.imm    = imm;
        return iss;
    endfunction

    task automatic add_row(input opc_t opc, input gp_addr_t tgt_gp, input sr_addr_t tgt_sr,
                           input gp_addr_t a, input gp_addr_t b, input imm_t imm,
                           input data_t exp);
        rows[row_cnt]    = mk_issue(opc, tgt_gp, tgt_sr, a, b, imm);
        row_exp[row_cnt] = exp;
        row_cnt++;
    endtask

    task automatic build_table();
        add_row(opc_movi,  4'd1,  2'd0, 4'd0,  4'd0,  8'h7f, 16'h007f);
        add_row(opc_movis, 4'd2,  2'd0, 4'd0,  4'd0,  8'h80, 16'hff80);
        add_row(opc_add,   4'd3,  2'd0, 4'd1,  4'd2,  8'h00, 16'hffff);  // r2 forwarded.
        add_row(opc_movi,  4'd4,  2'd0, 4'd0,  4'd0,  8'hff, 16'h00ff);
        add_row(opc_sub,   4'd5,  2'd0, 4'd4,  4'd1,  8'h00, 16'h0080);
        add_row(opc_not,   4'd6,  2'd0, 4'd5,  4'd0,  8'h00, 16'hff7f);
        add_row(opc_and,   4'd7,  2'd0, 4'd6,  4'd4,  8'h00, 16'h007f);
        add_row(opc_or,    4'd8,  2'd0, 4'd5,  4'd1,  8'h00, 16'h00ff);
        add_row(opc_xor,   4'd9,  2'd0, 4'd8,  4'd4,  8'h00, 16'h0000);
        add_row(opc_shl,   4'd10, 2'd0, 4'd1,  4'd4,  8'h00, 16'h8000);
        add_row(opc_shr,   4'd11, 2'd0, 4'd10, 4'd1,  8'h00, 16'h0001);
        add_row(opc_shri,  4'd12, 2'd0, 4'd3,  4'd0,  8'h01, 16'h7fff);
        add_row(opc_adds,  4'd13, 2'd0, 4'd12, 4'd1,  8'h00, 16'h7fff);  // clamps high.
        add_row(opc_subs,  4'd14, 2'd0, 4'd10, 4'd1,  8'h00, 16'h8000);  // clamps low.
        add_row(opc_shrs,  4'd15, 2'd0, 4'd10, 4'd11, 8'h00, 16'hc000);
        add_row(opc_addis, 4'd13, 2'd0, 4'd12, 4'd0,  8'h10, 16'h7fff);
        add_row(opc_subis, 4'd14, 2'd0, 4'd14, 4'd0,  8'h7f, 16'h8000);
        add_row(opc_shris, 4'd6,  2'd0, 4'd15, 4'd0,  8'h84, 16'hfc00);
        add_row(opc_addi,  4'd7,  2'd0, 4'd2,  4'd0,  8'h81, 16'h0001);
        add_row(opc_subi,  4'd8,  2'd0, 4'd7,  4'd0,  8'h02, 16'hffff);
        add_row(opc_andi,  4'd9,  2'd0, 4'd8,  4'd0,  8'hf0, 16'h00f0);
        add_row(opc_ori,   4'd9,  2'd0, 4'd9,  4'd0,  8'h0f, 16'h00ff);
        add_row(opc_xori,  4'd10, 2'd0, 4'd9,  4'd0,  8'haa, 16'h0055);
        add_row(opc_shli,  4'd11, 2'd0, 4'd10, 4'd0,  8'h13, 16'h02a8);
        add_row(opc_srmov, 4'd3,  2'd2, 4'd11, 4'd0,  8'h00, 16'h02a8);
        add_row(opc_mov,   4'd12, 2'd0, 4'd3,  4'd0,  8'h00, 16'hffff);  // r3 untouched.
        add_row(opc_srmov, 4'd0,  2'd1, 4'd5,  4'd0,  8'h00, 16'h0080);
    endtask

    // checks the two older instructions, then drives a new one.
    task automatic apply(input issue_t iss, input data_t exp);
        retire_t er;
        retire_t ew;
        retire_t ent;
        @(negedge iw_clk);
        er = exp_q.pop_front();
        ew = exp_q[0];
        check_pc(retire.pc, er.pc, "retire.pc");
        check_opc(retire.opc, er.opc, "retire.opc");
        check_instr(retire.instr, er.instr, "retire.instr");
        check_gp_addr(retire.tgt_gp, er.tgt_gp, "retire.tgt_gp");
        check_sr_addr(retire.tgt_sr, er.tgt_sr, "retire.tgt_sr");
        if (er.opc != opc_nop) check_data(retire.result, er.result, "retire.result");
        check_flag(gp_wr.en, writes_gp(ew.opc), "gp_wr.en");
        if (writes_gp(ew.opc)) begin
            check_gp_addr(gp_wr.addr, ew.tgt_gp, "gp_wr.addr");
            check_data(gp_wr.data, ew.result, "gp_wr.data");
        end
        check_flag(dut_i.sr_wr.en, ew.opc == opc_srmov, "sr_wr.en");
        if (ew.opc == opc_srmov) begin
            check_sr_addr(dut_i.sr_wr.addr, ew.tgt_sr, "sr_wr.addr");
            check_data(dut_i.sr_wr.data, ew.result, "sr_wr.data");
        end
        if (er.opc == opc_srmov) sr_model[er.tgt_sr] = er.result;
        check_data(sr_rd_data, sr_model[sr_rd_addr], "sr_rd_data");
        iss.pc     = next_pc;
        iss.instr  = {iss.opc, iss.tgt_gp, iss.src_a, iss.src_b[2:0]};
        next_pc    = next_pc + 16'd2;
        issue      = iss;
        sr_rd_addr = sr_addr_t'(step_cnt);
        step_cnt++;
        if (writes_gp(iss.opc)) gp_model[iss.tgt_gp] = exp;
        ent        = '0;
        ent.pc     = iss.pc;
        ent.instr  = iss.instr;
        ent.opc    = iss.opc;
        ent.tgt_gp = iss.tgt_gp;
        ent.tgt_sr = iss.tgt_sr;
        ent.result = exp;
        exp_q.push_back(ent);
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        issue_t      iss;
        logic [31:0] r;
        iw_rst     = 1'b1;
        issue      = '0;
        sr_rd_addr = '0;
        for (int i = 0; i < gp_n; i++) gp_model[i] = '0;
        for (int i = 0; i < sr_n; i++) sr_model[i] = '0;
        build_table();
        repeat (rst_cycles) begin
            @(negedge iw_clk);
            check_idle();
        end
        iw_rst = 1'b0;
        exp_q.push_back('0);    // both latches cleared.
        exp_q.push_back('0);
        for (int i = 0; i < n_rows; i++) begin
            apply(rows[i], row_exp[i]);
        end
        for (int i = 0; i < n_rand; i++) begin
            iss = '0;
            draw(5, r);
            r = r % 25 + 1;     // any opcode but nop.
            iss.opc = opc_t'(r[4:0]);
            draw(4, r);
            iss.tgt_gp = r[3:0];
            draw(2, r);
            iss.tgt_sr = r[1:0];
            draw(4, r);
            iss.src_a = r[3:0];
            draw(4, r);
            iss.src_b = r[3:0];
            draw(8, r);
            iss.imm = r[7:0];
            apply(iss, model_result(iss.opc, gp_model[iss.src_a], gp_model[iss.src_b], iss.imm));
        end
        repeat (2) apply(mk_issue(opc_nop, 4'd0, 2'd0, 4'd0, 4'd0, 8'h00), 16'h0000);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- compile.f
common/isa_pkg.sv
common/pipe_pkg.sv
verilog/register_file.sv
backend/exec_stage.sv
backend/writeback_stage.sv
backend/backend_top.sv
testbench/tb_backend.sv

//--- Bender.yml
package:
  name: backend

sources:
  # packages first
  - files:
      - common/isa_pkg.sv
      - common/pipe_pkg.sv

  # design
  - files:
      - verilog/register_file.sv
      - backend/exec_stage.sv
      - backend/writeback_stage.sv
      - backend/backend_top.sv

  # testbench
  - target: test
    files:
      - testbench/tb_backend.sv
